//--- common/sys_arr_pkg.sv
// sizes, register map and lane types of the 4x4 array; lane widths are fixed and word-only access
package sys_arr_pkg;

    localparam int ARR_DIM = 4;  // array edge
    localparam int MAX_VEC = 8;  // activation vectors per run
    localparam int ADDR_W  = 7;  // wishbone byte address
    localparam int LANE_W  = $clog2(ARR_DIM);
    localparam int VEC_W   = $clog2(MAX_VEC);
    localparam int CNT_W   = VEC_W + 1;  // counts up to MAX_VEC inclusive

    // register map, byte addresses
    localparam logic [ADDR_W-1:0] REG_CTRL        = 7'h00;  // wr bit0 start, rd bit0 busy bit1 done
    localparam logic [ADDR_W-1:0] REG_NUM_VEC     = 7'h04;
    localparam logic [ADDR_W-1:0] REG_WEIGHT_BASE = 7'h10;  // one word per weight row
    localparam logic [ADDR_W-1:0] REG_ACT_BASE    = 7'h20;  // one word per vector
    localparam logic [ADDR_W-1:0] REG_RESULT_BASE = 7'h40;  // two words per vector

    typedef logic signed [7:0]  act_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [15:0] sum_t;
    typedef logic [31:0]        wb_data_t;

    typedef weight_t [ARR_DIM-1:0] weight_row_t;  // column 0 in the low byte
    typedef sum_t    [ARR_DIM-1:0] sum_vec_t;

    typedef struct packed {
        logic active;
        act_t act;
    } act_lane_t;

    typedef struct packed {
        logic valid;
        sum_t sum;
    } sum_lane_t;

    typedef act_lane_t [ARR_DIM-1:0] act_lanes_t;
    typedef sum_lane_t [ARR_DIM-1:0] sum_lanes_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        wb_data_t          dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

endpackage

//--- verilog/pe.sv
// processing element; load and active must never overlap, sums wrap at 16 bits
`timescale 1ns/10ps

module pe import sys_arr_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    active,
    input  act_t    datain,
    input  weight_t win,
    input  sum_t    sumin,
    input  logic    wwrite,
    output sum_t    maccout,
    output act_t    dataout,
    output weight_t wout,
    output logic    wwriteout,
    output logic    activeout
);

    weight_t weight;  // stationary weight
    sum_t    prod;

    assign prod = datain * weight;  // sign extended to 16 bits before the multiply

    // weight and load go straight down, so a column shifts by one row per load cycle
    assign wout      = weight;
    assign wwriteout = wwrite;

    always_ff @(posedge clk) begin
        if (wwrite) begin
            weight <= win;
        end
        dataout <= datain;
        maccout <= active ? sumin + prod : sumin;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            activeout <= 1'b0;
        end else begin
            activeout <= active;
        end
    end

    // the sequencer finishes the weight shift before any vector enters
    load_vs_active: assert property (@(posedge clk) disable iff (rst)
        !(wwrite && active));

endmodule

//--- sys_arr/sys_arr_row.sv
// one row of ARR_DIM pe cells; data hops right one column per cycle and the right edge is dropped
`timescale 1ns/10ps

module sys_arr_row import sys_arr_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               active,
    input  act_t               datain,
    input  weight_row_t        win,
    input  sum_vec_t           sumin,
    input  logic               wwrite,
    output sum_vec_t           maccout,
    output weight_row_t        wout,
    output logic [ARR_DIM-1:0] activeout
);

    act_t data_hop [ARR_DIM];    // data entering each column
    act_t data_right [ARR_DIM];  // data leaving each column
    logic active_hop [ARR_DIM];

    for (genvar c = 0; c < ARR_DIM; c++) begin : gen_col
        if (c == 0) begin : gen_edge
            assign data_hop[c]   = datain;
            assign active_hop[c] = active;
        end else begin : gen_link
            assign data_hop[c]   = data_right[c-1];
            assign active_hop[c] = activeout[c-1];
        end

        pe pe_inst (
            .clk       (clk),
            .rst       (rst),
            .active    (active_hop[c]),
            .datain    (data_hop[c]),
            .win       (win[c]),
            .sumin     (sumin[c]),
            .wwrite    (wwrite),          // one load bit for every column
            .maccout   (maccout[c]),
            .dataout   (data_right[c]),
            .wout      (wout[c]),
            .wwriteout (),                // the array forwards load itself
            .activeout (activeout[c])
        );
    end

endmodule

//--- sys_arr/sys_arr.sv
// ARR_DIM rows stacked; row r expects its lane already delayed r cycles
`timescale 1ns/10ps

module sys_arr import sys_arr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  act_lanes_t  lanes,
    input  weight_row_t weight_in,
    input  logic        load,
    output sum_lanes_t  sums
);

    weight_row_t        w_chain [ARR_DIM+1];  // index r feeds row r
    sum_vec_t           s_chain [ARR_DIM+1];
    logic [ARR_DIM-1:0] act_rows [ARR_DIM];

    assign w_chain[0] = weight_in;
    assign s_chain[0] = '0;  // partial sums start at zero

    for (genvar r = 0; r < ARR_DIM; r++) begin : gen_row
        sys_arr_row row_inst (
            .clk       (clk),
            .rst       (rst),
            .active    (lanes[r].active),
            .datain    (lanes[r].act),
            .win       (w_chain[r]),
            .sumin     (s_chain[r]),
            .wwrite    (load),
            .maccout   (s_chain[r+1]),
            .wout      (w_chain[r+1]),
            .activeout (act_rows[r])
        );
    end

    // bottom row: sum and active bit of a column leave in the same cycle
    always_comb begin
        for (int c = 0; c < ARR_DIM; c++) begin
            sums[c].valid = act_rows[ARR_DIM-1][c];
            sums[c].sum   = s_chain[ARR_DIM][c];
        end
    end

endmodule

//--- verilog/lane_skew.sv
// triangular lane delay; lane_t must be a packed type whose msb-side zero means idle
`timescale 1ns/10ps

module lane_skew import sys_arr_pkg::*; #(
    parameter type lane_t  = act_lane_t,
    parameter bit  REVERSE = 1'b0  // set: lane i delayed ARR_DIM-1-i cycles
) (
    input  logic                    clk,
    input  logic                    rst,
    input  lane_t [ARR_DIM-1:0]     lanes_in,
    output lane_t [ARR_DIM-1:0]     lanes_out
);

    function automatic int delay_of(input int lane);
        return REVERSE ? ARR_DIM - 1 - lane : lane;
    endfunction

    for (genvar i = 0; i < ARR_DIM; i++) begin : gen_lane
        if (delay_of(i) == 0) begin : gen_pass
            assign lanes_out[i] = lanes_in[i];  // zero delay lane
        end else begin : gen_delay
            lane_t pipe [delay_of(i)];

            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int k = 0; k < delay_of(i); k++) begin
                        pipe[k] <= '0;  // clears the valid bit too
                    end
                end else begin
                    pipe[0] <= lanes_in[i];
                    for (int k = 1; k < delay_of(i); k++) begin
                        pipe[k] <= pipe[k-1];
                    end
                end
            end

            assign lanes_out[i] = pipe[delay_of(i)-1];
        end
    end

endmodule

//--- verilog/wb_sys_arr_ctrl.sv
// wishbone classic slave, full words only; writes other than start are dropped while busy
`timescale 1ns/10ps

module wb_sys_arr_ctrl import sys_arr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,
    output weight_row_t weight_out,
    output logic        load,
    output act_lanes_t  act_lanes,
    input  sum_lanes_t  sum_lanes
);

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_STREAM} state_t;

    state_t             state;
    logic               ack_q;
    logic               done;
    logic               busy;
    logic               issue_q;   // lanes carry a vector this cycle
    logic [CNT_W-1:0]   num_vec;
    logic [CNT_W-1:0]   vec_cnt;   // weight row step, then vectors issued
    logic [CNT_W-1:0]   res_cnt;   // results stored
    logic [LANE_W-1:0]  load_row;
    wb_data_t           issue_vec;
    wb_data_t           rsp_dat;
    wb_data_t           rd_data;
    weight_row_t        weight_buf [ARR_DIM];
    wb_data_t           act_buf [MAX_VEC];
    sum_vec_t           res_buf [MAX_VEC];
    sum_vec_t           arrived;
    logic [ARR_DIM-1:0] sum_valid;
    logic [ADDR_W-1:0]  adr;
    logic               req_new;
    logic               wr_idle;
    logic               start;
    logic               issue_now;
    logic               store_now;

    assign adr       = wb_req.adr;
    assign req_new   = wb_req.cyc && wb_req.stb && !ack_q;  // no ack right after an ack
    assign wr_idle   = req_new && wb_req.we && state == ST_IDLE;
    assign start     = wr_idle && adr == REG_CTRL && wb_req.dat[0];
    assign busy      = state != ST_IDLE;
    assign load_row  = LANE_W'(ARR_DIM - 1) - vec_cnt[LANE_W-1:0];  // last row goes in first
    assign issue_now = state == ST_STREAM && vec_cnt < num_vec;
    assign store_now = state == ST_STREAM && sum_lanes[0].valid;
    assign wb_rsp    = '{ack: ack_q, dat: rsp_dat};

    always_comb begin
        for (int i = 0; i < ARR_DIM; i++) begin
            act_lanes[i].active = issue_q;
            act_lanes[i].act    = act_t'(issue_vec[$bits(act_t)*i +: $bits(act_t)]);
            arrived[i]          = sum_lanes[i].sum;
            sum_valid[i]        = sum_lanes[i].valid;
        end
    end

    // buffer bases are aligned to their sizes, so the low address bits index directly
    always_comb begin
        rd_data = '0;
        if (adr == REG_CTRL) begin
            rd_data = wb_data_t'({done, busy});
        end else if (adr == REG_NUM_VEC) begin
            rd_data = wb_data_t'(num_vec);
        end else if (adr >= REG_RESULT_BASE) begin
            rd_data = res_buf[adr[VEC_W+2:3]][{adr[2], 1'b0} +: 2];  // even column low
        end else if (adr >= REG_ACT_BASE) begin
            rd_data = act_buf[adr[VEC_W+1:2]];
        end else if (adr >= REG_WEIGHT_BASE) begin
            rd_data = weight_buf[adr[LANE_W+1:2]];
        end
    end

    always_ff @(posedge clk) begin
        if (req_new) begin
            rsp_dat <= rd_data;
        end
        if (wr_idle && adr >= REG_WEIGHT_BASE && adr < REG_ACT_BASE) begin
            weight_buf[adr[LANE_W+1:2]] <= wb_req.dat;
        end
        if (wr_idle && adr >= REG_ACT_BASE && adr < REG_RESULT_BASE) begin
            act_buf[adr[VEC_W+1:2]] <= wb_req.dat;
        end
        if (state == ST_LOAD) begin
            weight_out <= weight_buf[load_row];
        end
        if (issue_now) begin
            issue_vec <= act_buf[vec_cnt[VEC_W-1:0]];
        end
        if (store_now) begin
            res_buf[res_cnt[VEC_W-1:0]] <= arrived;  // results kept in arrival order
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            ack_q   <= 1'b0;
            done    <= 1'b0;
            load    <= 1'b0;
            issue_q <= 1'b0;
            num_vec <= CNT_W'(1);
            vec_cnt <= '0;
            res_cnt <= '0;
        end else begin
            ack_q   <= req_new;
            load    <= state == ST_LOAD;
            issue_q <= issue_now;
            if (wr_idle && adr == REG_NUM_VEC && wb_req.dat != '0 && wb_req.dat <= MAX_VEC) begin
                num_vec <= wb_req.dat[CNT_W-1:0];
            end
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_LOAD;
                        done    <= 1'b0;
                        vec_cnt <= '0;
                        res_cnt <= '0;
                    end
                end
                ST_LOAD: begin
                    if (vec_cnt == CNT_W'(ARR_DIM - 1)) begin
                        state   <= ST_STREAM;
                        vec_cnt <= '0;
                    end else begin
                        vec_cnt <= vec_cnt + 1'b1;
                    end
                end
                ST_STREAM: begin
                    if (issue_now) begin
                        vec_cnt <= vec_cnt + 1'b1;
                    end
                    if (store_now) begin
                        res_cnt <= res_cnt + 1'b1;
                        if (res_cnt == num_vec - 1'b1) begin
                            state <= ST_IDLE;  // busy drops as done rises
                            done  <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb);

    // deskew must line up every column of one vector
    sums_aligned: assert property (@(posedge clk) disable iff (rst)
        |sum_valid |-> &sum_valid);

    no_idle_result: assert property (@(posedge clk) disable iff (rst)
        sum_lanes[0].valid |-> state != ST_IDLE);

endmodule

//--- verilog/sys_arr_top.sv
// systolic matrix multiplier behind a wishbone slave; the host polls done, no interrupt
`timescale 1ns/10ps

module sys_arr_top import sys_arr_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    weight_row_t weight_row;
    logic        load;
    act_lanes_t  act_issue;    // one vector, all lanes in the same cycle
    act_lanes_t  act_skewed;   // lane r delayed r cycles
    sum_lanes_t  sum_raw;      // column c finishes c cycles after column 0
    sum_lanes_t  sum_aligned;

    wb_sys_arr_ctrl ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .weight_out (weight_row),
        .load       (load),
        .act_lanes  (act_issue),
        .sum_lanes  (sum_aligned)
    );

    lane_skew #(.lane_t(act_lane_t), .REVERSE(1'b0)) act_skew_inst (
        .clk       (clk),
        .rst       (rst),
        .lanes_in  (act_issue),
        .lanes_out (act_skewed)
    );

    sys_arr arr_inst (
        .clk       (clk),
        .rst       (rst),
        .lanes     (act_skewed),
        .weight_in (weight_row),
        .load      (load),
        .sums      (sum_raw)
    );

    lane_skew #(.lane_t(sum_lane_t), .REVERSE(1'b1)) sum_deskew_inst (
        .clk       (clk),
        .rst       (rst),
        .lanes_in  (sum_raw),
        .lanes_out (sum_aligned)
    );

endmodule

//--- testbench/sys_arr_tb.sv
// testbench for sys_arr_top; run from the project root so the pattern file path resolves
`timescale 1ns/10ps

module sys_arr_tb import sys_arr_pkg::*; ();

    localparam int PAT_WORDS = 128;

    logic        clk = 1'b0;
    logic        rst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    wb_data_t    pat_mem [PAT_WORDS];
    wb_data_t    w_words [ARR_DIM];        // weight rows of the current test
    wb_data_t    a_words [MAX_VEC];        // activation vectors
    wb_data_t    e_words [2*MAX_VEC];      // expected result words
    wb_data_t    res_words [2*MAX_VEC];    // result words read back
    logic [31:0] rng;
    int          cycles = 0;
    int          limit;

    sys_arr_top sys_arr_top_i (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Verification failed");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // column c of act times W, wrapped to 16 bits
    function automatic sum_t col_sum(input wb_data_t a, input int c);
        sum_t acc;
        acc = '0;
        for (int r = 0; r < ARR_DIM; r++) begin
            acc = acc + sum_t'(act_t'(a[8*r +: 8])) * sum_t'(weight_t'(w_words[r][8*c +: 8]));
        end
        return acc;
    endfunction

    function automatic logic [ADDR_W-1:0] reg_addr(input logic [ADDR_W-1:0] base, input int idx);
        return base + ADDR_W'(4 * idx);  // word addresses
    endfunction

    task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_sum(input string name, input sum_t exp, input sum_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
            $display("Verification failed");
            $fatal(1, "sum mismatch");
        end
    endtask

    task automatic check_status(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected done,busy %b, actual %b", name, exp, act);
            $display("Verification failed");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic wait_ack();
        @(negedge clk);
        while (!wb_rsp.ack) begin
            @(negedge clk);
        end
    endtask

    task automatic wb_write(input logic [ADDR_W-1:0] addr, input wb_data_t data);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = addr;
        wb_req.dat = data;
        wait_ack();
        @(negedge clk);  // request held through the edge that samples ack
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [ADDR_W-1:0] addr, output wb_data_t data);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = addr;
        wb_req.dat = '0;
        wait_ack();
        data = wb_rsp.dat;  // valid while ack is high
        @(negedge clk);
        wb_req = '0;
    endtask

    // load buffers, check readback, run, check busy handling, fetch results
    task automatic run_vectors(input string name, input int n);
        wb_data_t rd;
        for (int r = 0; r < ARR_DIM; r++) begin
            wb_write(reg_addr(REG_WEIGHT_BASE, r), w_words[r]);
        end
        for (int v = 0; v < n; v++) begin
            wb_write(reg_addr(REG_ACT_BASE, v), a_words[v]);
        end
        wb_write(REG_NUM_VEC, wb_data_t'(n));
        for (int r = 0; r < ARR_DIM; r++) begin
            wb_read(reg_addr(REG_WEIGHT_BASE, r), rd);
            check_word({name, " weight readback"}, w_words[r], rd);
        end
        for (int v = 0; v < n; v++) begin
            wb_read(reg_addr(REG_ACT_BASE, v), rd);
            check_word({name, " activation readback"}, a_words[v], rd);
        end
        wb_read(REG_NUM_VEC, rd);
        check_word({name, " count readback"}, wb_data_t'(n), rd);
        wb_write(REG_CTRL, 32'h1);
        wb_read(REG_CTRL, rd);
        check_status({name, " busy after start"}, 2'b01, rd[1:0]);  // done cleared by start
        wb_write(reg_addr(REG_WEIGHT_BASE, 0), ~w_words[0]);       // must be dropped
        wb_read(reg_addr(REG_WEIGHT_BASE, 0), rd);
        check_word({name, " weight write while busy"}, w_words[0], rd);
        rd = '0;
        while (!rd[1]) begin
            wb_read(REG_CTRL, rd);
        end
        check_status({name, " done"}, 2'b10, rd[1:0]);
        for (int i = 0; i < 2*n; i++) begin
            wb_read(reg_addr(REG_RESULT_BASE, i), res_words[i]);
        end
    endtask

    initial begin : main
        int       idx;
        int       n;
        int       t;
        int       n_tests;
        int       n_vec;
        wb_data_t rd;
        string    name;

        wb_req = '0;
        rst    = 1'b1;
        rng    = 32'hd29a_d0b8;
        $readmemh("testbench/sys_arr_patterns.hex", pat_mem);

        // scan the file once for the cycle budget, random test included
        idx     = 0;
        n_tests = 1;
        n_vec   = MAX_VEC;
        while (pat_mem[idx] !== '0) begin
            if ($isunknown(pat_mem[idx]) || pat_mem[idx] > MAX_VEC) begin
                $display("pattern file is missing or has a bad count at word %0d", idx);
                $display("Verification failed");
                $fatal(1, "bad pattern file");
            end
            n_tests++;
            n_vec += pat_mem[idx];
            idx += 1 + ARR_DIM + 3 * pat_mem[idx];
        end
        limit = 200 * n_tests + 20 * n_vec;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        wb_read(REG_CTRL, rd);
        check_status("status after reset", 2'b00, rd[1:0]);

        idx = 0;
        t   = 0;
        while (pat_mem[idx] !== '0) begin
            n    = pat_mem[idx];
            name = $sformatf("pattern test %0d", t);
            for (int r = 0; r < ARR_DIM; r++) begin
                w_words[r] = pat_mem[idx + 1 + r];
            end
            for (int v = 0; v < n; v++) begin
                a_words[v] = pat_mem[idx + 1 + ARR_DIM + v];
            end
            for (int i = 0; i < 2*n; i++) begin
                e_words[i] = pat_mem[idx + 1 + ARR_DIM + n + i];
            end
            run_vectors(name, n);
            for (int i = 0; i < 2*n; i++) begin
                check_word($sformatf("%s result word %0d", name, i), e_words[i], res_words[i]);
            end
            idx += 1 + ARR_DIM + 3 * n;
            t++;
        end

        for (int r = 0; r < ARR_DIM; r++) begin
            rng        = xorshift(rng);
            w_words[r] = rng;
        end
        for (int v = 0; v < MAX_VEC; v++) begin
            rng        = xorshift(rng);
            a_words[v] = rng;
        end
        run_vectors("random test", MAX_VEC);
        for (int v = 0; v < MAX_VEC; v++) begin
            for (int c = 0; c < ARR_DIM; c++) begin
                check_sum($sformatf("random test vector %0d column %0d", v, c),
                    col_sum(a_words[v], c), sum_t'(res_words[2*v + c/2][16*(c%2) +: 16]));
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

//--- testbench/sys_arr_patterns.hex
// one word per line: vector count, 4 weight rows (column 0 in the low byte), count activation
// words (element 0 low), then 2 result words per vector (even column low); count 0 ends the file
// identity weights, 2 vectors
00000002
00000001
00000100
00010000
01000000
807FFB05
01C83412
FFFB0005
FF80007F
00340012
0001FFC8
// mixed signs, 4 vectors in flight
00000004
FC03FE01
05FF0302
020401FD
01FEFF04
04030201
FCFDFEFF
D81EEC0A
0500807F
0003000C
00100005
FFFDFFF4
FFF0FFFB
FFF6FEE8
FF8800FA
FD7DFF93
FB8901F3
// column sums past the 16 bit range wrap
00000001
80807F80
80807F80
FF807F80
00007F80
80808080
02000000
8080C000
// end of tests
00000000

//--- flist.f
common/sys_arr_pkg.sv
verilog/pe.sv
sys_arr/sys_arr_row.sv
sys_arr/sys_arr.sv
verilog/lane_skew.sv
verilog/wb_sys_arr_ctrl.sv
verilog/sys_arr_top.sv
testbench/sys_arr_tb.sv

//--- Bender.yml
package:
  name: sys_arr

sources:
  - files:
      - common/sys_arr_pkg.sv
      - verilog/pe.sv
      - sys_arr/sys_arr_row.sv
      - sys_arr/sys_arr.sv
      - verilog/lane_skew.sv
      - verilog/wb_sys_arr_ctrl.sv
      - verilog/sys_arr_top.sv
  - target: test
    files:
      - testbench/sys_arr_tb.sv
